// File: verilog/mem_pkg.sv
package mem_pkg;

   localparam int word_bits = 32;   // data path width
   localparam int addr_bits = 32;   // byte address width
   localparam int lane_count = 4;   // byte lanes per word
   localparam int lane_bits = 8;    // bits per lane

   typedef logic [word_bits-1:0] word_t;

   // access kind as seen by the processor
   typedef enum logic [3:0] {
      op_none = 4'd0,
      op_lb   = 4'd1,
      op_lh   = 4'd2,
      op_lw   = 4'd3,
      op_lbu  = 4'd4,
      op_lhu  = 4'd5,
      op_sb   = 4'd6,
      op_sh   = 4'd7,
      op_sw   = 4'd8
   } mem_op_e;

   // processor side request
   typedef struct packed {
      mem_op_e                op;     // what to do
      logic [addr_bits-1:0]   addr;   // byte address
      word_t                  wdata;  // store data in low bytes
   } mem_req_t;

   // memory bus command
   typedef struct packed {
      logic [addr_bits-1:0]   address;     // byte address, word index from bit 2
      word_t                  write_data;  // unshifted store data
      logic                   mem_read;    // read enable
      logic                   mem_write;   // write enable
      logic [lane_count-1:0]  mask_byte;   // lane 0 is lsb
   } mem_cmd_t;

endpackage

// File: verilog/mem_access_ctrl.sv
module mem_access_ctrl (
   input  logic              clk,         // assertion clocking only
   input  logic              rst,         // assertion disable only
   input  mem_pkg::mem_req_t req,
   output mem_pkg::mem_cmd_t cmd,
   output logic              misaligned
);

   logic       is_load;     // op reads memory
   logic       is_store;    // op writes memory
   logic [1:0] size;        // 0 byte, 1 half, 2 word
   logic [1:0] lane;        // low address bits
   logic       aligned;     // address fits the size
   logic [3:0] lane_mask;   // lanes touched when aligned
   logic       access;      // legal access going out

   assign lane = req.addr[1:0];

   // op decode into direction and size
   always_comb begin
      is_load = 1'b0;
      is_store = 1'b0;
      size = 2'd0;
      case (req.op)
         mem_pkg::op_lb, mem_pkg::op_lbu: begin
            is_load = 1'b1;
         end
         mem_pkg::op_lh, mem_pkg::op_lhu: begin
            is_load = 1'b1;
            size = 2'd1;
         end
         mem_pkg::op_lw: begin
            is_load = 1'b1;
            size = 2'd2;
         end
         mem_pkg::op_sb: begin
            is_store = 1'b1;
         end
         mem_pkg::op_sh: begin
            is_store = 1'b1;
            size = 2'd1;
         end
         mem_pkg::op_sw: begin
            is_store = 1'b1;
            size = 2'd2;
         end
         default: ;   // op_none, nothing happens
      endcase
   end

   // lane mask and alignment from size
   always_comb begin
      case (size)
         2'd0: begin
            aligned = 1'b1;                 // bytes always fit
            lane_mask = 4'b0001 << lane;    // single lane
         end
         2'd1: begin
            aligned = ~lane[0];             // even address needed
            lane_mask = lane[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            aligned = (lane == 2'd0);       // word boundary needed
            lane_mask = 4'b1111;
         end
      endcase
   end

   assign access = (is_load | is_store) & aligned;
   assign misaligned = (is_load | is_store) & ~aligned;

   assign cmd.address = req.addr;
   assign cmd.write_data = req.wdata;
   assign cmd.mem_read = is_load & aligned;      // suppressed when misaligned
   assign cmd.mem_write = is_store & aligned;
   assign cmd.mask_byte = access ? lane_mask : 4'b0000;

   // a flagged access must never reach the memory
   a_misaligned_quiet: assert property (@(posedge clk) disable iff (rst)
      misaligned |-> !(cmd.mem_read || cmd.mem_write))
      else $error("misaligned access leaked onto the memory bus");

endmodule

// File: verilog/data_mem.sv
module data_mem #(
   parameter int addr_width = 10   // word index bits
) (
   input  logic              clk,
   input  logic              rst,
   input  mem_pkg::mem_cmd_t cmd,
   output mem_pkg::word_t    read_word,
   input  mem_pkg::word_t    pc,
   output mem_pkg::word_t    instruction
);

   // word array, four byte lanes each
   logic [mem_pkg::lane_count-1:0][mem_pkg::lane_bits-1:0] mem [2**addr_width];

   logic [addr_width-1:0] data_idx;    // word index for data port
   logic [addr_width-1:0] fetch_idx;   // word index for fetch port
   mem_pkg::word_t        wval;        // store data

   assign data_idx = cmd.address[addr_width+1:2];   // byte address to word
   assign fetch_idx = pc[addr_width+1:2];           // same bits of pc
   assign wval = cmd.write_data;

   assign instruction = mem[fetch_idx];                 // fetch is always live
   assign read_word = cmd.mem_read ? mem[data_idx] : '0; // zero when idle

   // lane writes, low bits of store data go into the masked lanes
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mem <= '{default: '0};   // whole array cleared
      end else if (cmd.mem_write) begin
         case (cmd.mask_byte)
            4'b0001: mem[data_idx][0] <= wval[7:0];
            4'b0010: mem[data_idx][1] <= wval[7:0];
            4'b0100: mem[data_idx][2] <= wval[7:0];
            4'b1000: mem[data_idx][3] <= wval[7:0];
            4'b0011: mem[data_idx][1:0] <= wval[15:0];   // little endian pair
            4'b0110: mem[data_idx][2:1] <= wval[15:0];   // middle pair
            4'b1100: mem[data_idx][3:2] <= wval[15:0];
            4'b1111: mem[data_idx] <= wval;              // full word
            default: ;                                   // other masks ignored
         endcase
      end
   end

   // only the eight decoded masks may come with a write
   a_legal_mask: assert property (@(posedge clk) disable iff (rst)
      cmd.mem_write |-> cmd.mask_byte inside {4'd1, 4'd2, 4'd4, 4'd8,
                                              4'd3, 4'd6, 4'd12, 4'd15})
      else $error("write with illegal lane mask %b", cmd.mask_byte);

   // bus is single direction per cycle
   a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
      !(cmd.mem_read && cmd.mem_write))
      else $error("read and write requested in the same cycle");

endmodule

// File: verilog/load_align.sv
module load_align (
   input  mem_pkg::mem_op_e op,
   input  logic [1:0]       byte_sel,    // low address bits
   input  mem_pkg::word_t   read_word,
   output mem_pkg::word_t   load_data
);

   logic [7:0]  sel_byte;   // addressed byte
   logic [15:0] sel_half;   // addressed halfword

   // byte pick by lane
   always_comb begin
      case (byte_sel)
         2'd0: sel_byte = read_word[7:0];
         2'd1: sel_byte = read_word[15:8];
         2'd2: sel_byte = read_word[23:16];
         default: sel_byte = read_word[31:24];
      endcase
   end

   // halfword pick, bit 0 is clear for legal halves
   assign sel_half = byte_sel[1] ? read_word[31:16] : read_word[15:0];

   // extension per op
   always_comb begin
      case (op)
         mem_pkg::op_lb: begin
            load_data = {{24{sel_byte[7]}}, sel_byte};    // sign extend
         end
         mem_pkg::op_lbu: begin
            load_data = {24'd0, sel_byte};                // zero extend
         end
         mem_pkg::op_lh: begin
            load_data = {{16{sel_half[15]}}, sel_half};
         end
         mem_pkg::op_lhu: begin
            load_data = {16'd0, sel_half};
         end
         mem_pkg::op_lw: begin
            load_data = read_word;                        // whole word
         end
         default: begin
            load_data = '0;                               // stores and none
         end
      endcase
   end

endmodule

// File: verilog/mem_subsys.sv
module mem_subsys #(
   parameter int addr_width = 10   // word index bits, 1024 words
) (
   input  logic              clk,
   input  logic              rst,
   input  mem_pkg::mem_req_t req,
   input  mem_pkg::word_t    pc,
   output mem_pkg::word_t    load_data,
   output mem_pkg::word_t    instruction,
   output logic              misaligned
);

   mem_pkg::mem_cmd_t cmd;         // controller to memory
   mem_pkg::word_t    read_word;   // memory to aligner

   // request to bus command
   mem_access_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .cmd        (cmd),
      .misaligned (misaligned)
   );

   // storage with data and fetch ports
   data_mem #(
      .addr_width (addr_width)
   ) u_mem (
      .clk         (clk),
      .rst         (rst),
      .cmd         (cmd),
      .read_word   (read_word),
      .pc          (pc),
      .instruction (instruction)
   );

   // byte and halfword extraction
   load_align u_align (
      .op        (req.op),
      .byte_sel  (req.addr[1:0]),
      .read_word (read_word),
      .load_data (load_data)
   );

endmodule

// File: sim/mem_subsys_tb.sv
module mem_subsys_tb;

   localparam int addr_width = 6;                   // 64 words keeps the space small
   localparam int mem_bytes = 4 * (2 ** addr_width);

   logic              clk = 1'b0;
   logic              rst = 1'b1;
   mem_pkg::mem_req_t req = '0;
   mem_pkg::word_t    pc = '0;
   mem_pkg::word_t    load_data;
   mem_pkg::word_t    instruction;
   logic              misaligned;

   logic [7:0]  shadow [mem_bytes];       // byte image of the memory
   logic [31:0] lfsr = 32'h424bfe02;      // random source state
   int          errors = 0;
   int          timeouts = 0;
   string       test_name = "reset";      // set by the sequence
   string       active_name = "reset";    // follows req by one edge

   logic [addr_width+1:0] ba;     // byte index of request
   logic [addr_width-1:0] widx;   // word index of request
   logic [addr_width-1:0] fidx;   // word index of pc
   logic [7:0]            sel_b;  // addressed byte in model
   logic [15:0]           sel_h;  // addressed halfword in model
   mem_pkg::word_t        data_word;
   mem_pkg::word_t        exp_load;
   mem_pkg::word_t        exp_instr;
   logic                  exp_mis;

   mem_subsys #(
      .addr_width (addr_width)
   ) uut (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .pc          (pc),
      .load_data   (load_data),
      .instruction (instruction),
      .misaligned  (misaligned)
   );

   always #5 clk = ~clk;   // period 10

   // model predictions from the byte image
   always_comb begin
      ba = req.addr[addr_width+1:0];
      widx = ba[addr_width+1:2];
      fidx = pc[addr_width+1:2];
      sel_b = shadow[ba];
      sel_h = {shadow[{widx, ba[1], 1'b1}], shadow[{widx, ba[1], 1'b0}]};   // little endian
      data_word = {shadow[{widx, 2'd3}], shadow[{widx, 2'd2}],
                   shadow[{widx, 2'd1}], shadow[{widx, 2'd0}]};
      exp_instr = {shadow[{fidx, 2'd3}], shadow[{fidx, 2'd2}],
                   shadow[{fidx, 2'd1}], shadow[{fidx, 2'd0}]};
      case (req.op)
         mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: exp_mis = ba[0];
         mem_pkg::op_lw, mem_pkg::op_sw: exp_mis = (ba[1:0] != 2'b00);
         default: exp_mis = 1'b0;   // bytes and none always fit
      endcase
      case (req.op)
         mem_pkg::op_lb: exp_load = {{24{sel_b[7]}}, sel_b};
         mem_pkg::op_lbu: exp_load = {24'd0, sel_b};
         mem_pkg::op_lh: exp_load = {{16{sel_h[15]}}, sel_h};
         mem_pkg::op_lhu: exp_load = {16'd0, sel_h};
         mem_pkg::op_lw: exp_load = data_word;
         default: exp_load = '0;    // stores and none
      endcase
      if (exp_mis) begin
         exp_load = '0;             // suppressed access reads nothing
      end
   end

   // stores land in the image at the edge that ends their cycle
   always @(posedge clk) begin
      if (rst) begin
         shadow <= '{default: 8'h00};
      end else if (!exp_mis) begin
         case (req.op)
            mem_pkg::op_sb: shadow[ba] <= req.wdata[7:0];
            mem_pkg::op_sh: begin
               shadow[{widx, ba[1], 1'b0}] <= req.wdata[7:0];
               shadow[{widx, ba[1], 1'b1}] <= req.wdata[15:8];
            end
            mem_pkg::op_sw: begin
               shadow[{widx, 2'd0}] <= req.wdata[7:0];
               shadow[{widx, 2'd1}] <= req.wdata[15:8];
               shadow[{widx, 2'd2}] <= req.wdata[23:16];
               shadow[{widx, 2'd3}] <= req.wdata[31:24];
            end
            default: ;
         endcase
      end
   end

   // outputs are stable at the falling edge
   a_load_value: assert property (@(negedge clk) disable iff (rst) load_data == exp_load)
      else begin
         errors++;
         $display("Error: %s load_data expected %h actual %h", active_name, exp_load, load_data);
      end

   a_fetch_value: assert property (@(negedge clk) disable iff (rst) instruction == exp_instr)
      else begin
         errors++;
         $display("Error: %s instruction expected %h actual %h",
                  active_name, exp_instr, instruction);
      end

   a_misaligned_flag: assert property (@(negedge clk) disable iff (rst) misaligned == exp_mis)
      else begin
         errors++;
         $display("Error: %s misaligned expected %b actual %b", active_name, exp_mis, misaligned);
      end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois step with taps 32 22 2 1
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic drive_req(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                            input mem_pkg::word_t wdata, input mem_pkg::word_t pcv);
      @(posedge clk);
      req.op <= op;
      req.addr <= addr;
      req.wdata <= wdata;
      pc <= pcv;
      active_name <= test_name;   // name travels with the request
   endtask

   // cleared memory shows zero on both ports
   task automatic wait_reset_clear(output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < 10 && !ok; n++) begin
         @(negedge clk);
         if (!rst && instruction == '0 && load_data == '0 && !misaligned) begin
            ok = 1'b1;
         end
      end
      if (!ok) begin
         timeouts++;
         $display("timeout: memory outputs did not settle to zero after reset");
      end
   endtask

   initial begin
      bit               ok;
      int               i;
      int               k;
      int               lane;
      logic [31:0]      r;
      logic [31:0]      base;
      logic [31:0]      a;
      mem_pkg::word_t   w;
      mem_pkg::mem_op_e op;

      repeat (4) @(posedge clk);
      rst <= 1'b0;
      wait_reset_clear(ok);
      if (ok) begin
         test_name = "reset_clear";
         for (i = 0; i < 2 ** addr_width; i++) begin
            drive_req(mem_pkg::op_lw, i * 4, '0, i * 4);
         end

         test_name = "word_store";
         for (i = 0; i < 8; i++) begin
            r = rand_bits(addr_width);
            base = {r[29:0], 2'b00};
            w = rand_bits(32);
            drive_req(mem_pkg::op_sw, base, w, base);
            drive_req(mem_pkg::op_lw, base, '0, base);   // data and fetch agree
         end

         test_name = "lane_store";
         r = rand_bits(addr_width);
         base = {r[29:0], 2'b00};
         for (lane = 0; lane < 4; lane++) begin
            drive_req(mem_pkg::op_sb, base + lane, rand_bits(32), base);
            drive_req(mem_pkg::op_lw, base, '0, base);
         end
         for (lane = 0; lane < 4; lane += 2) begin
            drive_req(mem_pkg::op_sh, base + lane, rand_bits(32), base);
            drive_req(mem_pkg::op_lw, base, '0, base);
         end

         test_name = "load_extend";
         for (k = 0; k < 2; k++) begin
            w = (k == 0) ? 32'h8f7af016 : 32'hc3a55a3c;   // both signs in bytes and halves
            drive_req(mem_pkg::op_sw, base, w, base);
            for (lane = 0; lane < 4; lane++) begin
               drive_req(mem_pkg::op_lb, base + lane, '0, base);
               drive_req(mem_pkg::op_lbu, base + lane, '0, base);
            end
            for (lane = 0; lane < 4; lane += 2) begin
               drive_req(mem_pkg::op_lh, base + lane, '0, base);
               drive_req(mem_pkg::op_lhu, base + lane, '0, base);
            end
         end

         test_name = "misaligned";
         drive_req(mem_pkg::op_sw, base, rand_bits(32), base);
         for (lane = 1; lane < 4; lane += 2) begin
            drive_req(mem_pkg::op_lh, base + lane, '0, base);
            drive_req(mem_pkg::op_lhu, base + lane, '0, base);
            drive_req(mem_pkg::op_sh, base + lane, rand_bits(32), base);
         end
         for (lane = 1; lane < 4; lane++) begin
            drive_req(mem_pkg::op_lw, base + lane, '0, base);
            drive_req(mem_pkg::op_sw, base + lane, rand_bits(32), base);
         end
         drive_req(mem_pkg::op_lw, base, '0, base);   // read back the untouched word

         test_name = "random_mix";
         for (i = 0; i < 300; i++) begin
            r = rand_bits(4);
            op = mem_pkg::mem_op_e'(r[3:0] % 4'd9);
            a = rand_bits(addr_width + 2);
            r = rand_bits(1);
            if (r[0]) begin
               a[1:0] = 2'b00;   // lean toward aligned
            end
            w = rand_bits(32);
            r = rand_bits(addr_width);
            drive_req(op, a, w, {r[29:0], 2'b00});
         end
      end

      drive_req(mem_pkg::op_none, '0, '0, '0);
      @(posedge clk);   // falling edge checks of the last request have run
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: flist.f
verilog/mem_pkg.sv
verilog/mem_access_ctrl.sv
verilog/data_mem.sv
verilog/load_align.sv
verilog/mem_subsys.sv
sim/mem_subsys_tb.sv

// File: Makefile
TOP = mem_subsys_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
